/* fault_monitor.sv */
//////////////////////////////
// leaky error counters per replica, sticky permanent fault flags
// hands the spare lane to the first replica that turns faulty
//////////////////////////////

`timescale 1ns/1ns

module fault_monitor (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [mult_ft_pkg::N_REPLICA-1:0] mismatch_i,
	input  logic                              done_i,
	input  logic                              ex_ready_i,
	output logic [mult_ft_pkg::N_REPLICA-1:0] spare_sel_o,
	output logic [mult_ft_pkg::N_REPLICA-1:0] perm_faulty_o
);
	import mult_ft_pkg::*;

	logic                   accept;
	logic [FAULT_CNT_W-1:0] cnt_q [N_REPLICA];
	logic [FAULT_CNT_W-1:0] cnt_d [N_REPLICA];
	logic [N_REPLICA-1:0]   spare_d;
	logic [N_REPLICA-1:0]   perm_d;
	logic                   spare_taken;

	// only a completed operation taken by the stage is judged
	assign accept = done_i & ex_ready_i;

	//////////////////////////////
	// counter and flag update
	//////////////////////////////

	always_comb begin
		spare_taken = |spare_sel_o;
		spare_d     = spare_sel_o;
		perm_d      = perm_faulty_o;
		for (int k = 0; k < N_REPLICA; k++) begin
			cnt_d[k] = cnt_q[k];
			if (accept) begin
				// up on a mismatch, saturating
				if (mismatch_i[k]) begin
					if (cnt_q[k] != '1) begin
						cnt_d[k] = cnt_q[k] + 1'b1;
					end
				end else if (cnt_q[k] != '0) begin
					// leak one step per clean operation
					cnt_d[k] = cnt_q[k] - 1'b1;
				end
			end
			if (!perm_faulty_o[k] && (cnt_d[k] >= FAULT_THRESHOLD)) begin
				perm_d[k] = 1'b1;
				// single spare, lower index wins a tie
				if (!spare_taken) begin
					spare_d[k]  = 1'b1;
					spare_taken = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < N_REPLICA; k++) begin
				cnt_q[k] <= '0;
			end
			spare_sel_o   <= '0;
			perm_faulty_o <= '0;
		end else begin
			for (int k = 0; k < N_REPLICA; k++) begin
				cnt_q[k] <= cnt_d[k];
			end
			spare_sel_o   <= spare_d;
			perm_faulty_o <= perm_d;
		end
	end

endmodule

/* mult_core.sv */
//////////////////////////////
// one multiplier replica with lane or spare input steering
// mul/mac are combinational, mulh/mulhu answer one cycle after issue
//////////////////////////////

`timescale 1ns/1ns

module mult_core (
	input  logic                  clk,
	input  logic                  rst_n,
	// own lane
	input  logic                  enable_i,
	input  mult_ft_pkg::mult_op_e operator_i,
	input  mult_ft_pkg::data_t    op_a_i,
	input  mult_ft_pkg::data_t    op_b_i,
	input  mult_ft_pkg::data_t    op_c_i,
	// spare lane
	input  logic                  spare_enable_i,
	input  mult_ft_pkg::mult_op_e spare_operator_i,
	input  mult_ft_pkg::data_t    spare_op_a_i,
	input  mult_ft_pkg::data_t    spare_op_b_i,
	input  mult_ft_pkg::data_t    spare_op_c_i,
	input  logic                  spare_sel_i,
	input  logic                  ex_ready_i,
	output mult_ft_pkg::data_t    result_o,
	output logic                  multicycle_o,
	output logic                  ready_o,
	output logic                  done_o
);
	import mult_ft_pkg::*;

	// operands after the lane mux
	logic                  enable;
	mult_op_e              operator;
	data_t                 op_a;
	data_t                 op_b;
	data_t                 op_c;

	logic signed [2*DATA_W-1:0] prod_s;
	logic [2*DATA_W-1:0]   prod_u;
	data_t                 result_lo;
	data_t                 high_d;
	data_t                 high_q;
	logic                  is_high_op;

	mult_state_e           state_q;
	mult_state_e           state_d;

	//////////////////////////////
	// input steering
	//////////////////////////////

	// spare_sel switches the whole operation over to the spare lane
	assign enable   = spare_sel_i ? spare_enable_i   : enable_i;
	assign operator = spare_sel_i ? spare_operator_i : operator_i;
	assign op_a     = spare_sel_i ? spare_op_a_i     : op_a_i;
	assign op_b     = spare_sel_i ? spare_op_b_i     : op_b_i;
	assign op_c     = spare_sel_i ? spare_op_c_i     : op_c_i;

	//////////////////////////////
	// products
	//////////////////////////////

	// full 64 bit products, explicit sign or zero extension
	assign prod_s = $signed({{DATA_W{op_a[DATA_W-1]}}, op_a}) *
	                $signed({{DATA_W{op_b[DATA_W-1]}}, op_b});
	assign prod_u = {{DATA_W{1'b0}}, op_a} * {{DATA_W{1'b0}}, op_b};

	// low half is the same for signed and unsigned
	assign result_lo = (operator == MAC) ? prod_u[DATA_W-1:0] + op_c : prod_u[DATA_W-1:0];

	assign is_high_op = (operator == MULH) || (operator == MULHU);
	assign high_d     = (operator == MULH) ? prod_s[2*DATA_W-1:DATA_W] : prod_u[2*DATA_W-1:DATA_W];

	//////////////////////////////
	// high half fsm
	//////////////////////////////

	always_comb begin
		state_d      = state_q;
		multicycle_o = 1'b0;
		ready_o      = 1'b1;
		result_o     = result_lo;
		case (state_q)
			IDLE: begin
				// issue cycle of a high half, not ready yet
				if (enable && is_high_op) begin
					multicycle_o = 1'b1;
					ready_o      = 1'b0;
					state_d      = HIGH;
				end
			end
			HIGH: begin
				// hold the registered half while the stage is stalled
				result_o = high_q;
				if (ex_ready_i) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	// enabled operation completing in this cycle
	assign done_o = enable & ready_o;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// capture the upper half at issue, operands are stable here
	always_ff @(posedge clk) begin
		if ((state_q == IDLE) && enable && is_high_op) begin
			high_q <= high_d;
		end
	end

endmodule

/* mult_ft_assertions.sv */
//////////////////////////////
// concurrent checks on the multiplier top, bound into it
// accepted results are compared with a model of lane 1
//////////////////////////////

`timescale 1ns/1ns

module mult_ft_assertions (
	input logic                              clk,
	input logic                              rst_n,
	input logic                              lane_en_i,
	input mult_ft_pkg::mult_op_e             lane_op_i,
	input mult_ft_pkg::data_t                lane_a_i,
	input mult_ft_pkg::data_t                lane_b_i,
	input mult_ft_pkg::data_t                lane_c_i,
	input logic                              ex_ready_i,
	input mult_ft_pkg::data_t                result_i,
	input logic                              multicycle_i,
	input logic                              ready_i,
	input logic                              err_detected_i,
	input logic                              err_corrected_i,
	input logic [mult_ft_pkg::N_REPLICA-1:0] perm_faulty_i
);
	import mult_ft_pkg::*;

	// failures so far, watched from the testbench
	int unsigned fail_cnt = 0;
	data_t       model;
	logic        accepted;
	logic        vote_ok;

	// operation rules applied to one lane
	function automatic data_t model_result(input mult_op_e op, input data_t a,
			input data_t b, input data_t c);
		logic signed [2*DATA_W-1:0] full_s;
		logic [2*DATA_W-1:0]        full_u;
		full_s = (2*DATA_W)'($signed(a)) * (2*DATA_W)'($signed(b));
		full_u = (2*DATA_W)'(a) * (2*DATA_W)'(b);
		case (op)
			MUL:     return full_u[DATA_W-1:0];
			MAC:     return full_u[DATA_W-1:0] + c;
			MULH:    return full_s[2*DATA_W-1:DATA_W];
			default: return full_u[2*DATA_W-1:DATA_W];
		endcase
	endfunction

	assign model    = model_result(lane_op_i, lane_a_i, lane_b_i, lane_c_i);
	assign accepted = lane_en_i & ready_i & ex_ready_i;
	// two outvoted replicas leave the vote without a trusted value
	assign vote_ok  = !err_detected_i || err_corrected_i;

	//////////////////////////////
	// results and handshake
	//////////////////////////////

	a_result: assert property (@(posedge clk) disable iff (!rst_n)
		accepted && vote_ok |-> result_i == model)
	else begin
		fail_cnt++;
		$error("Fail result_o got %h expected %h", $sampled(result_i), $sampled(model));
	end

	a_multi_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
		multicycle_i |-> !ready_i)
	else begin
		fail_cnt++;
		$error("ready_o is high in the same cycle as multicycle_o");
	end

	a_high_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		multicycle_i |=> ready_i)
	else begin
		fail_cnt++;
		$error("ready_o did not rise one cycle after multicycle_o");
	end

	// stalled stage, whole output holds
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		lane_en_i && ready_i && !ex_ready_i |=> ready_i && $stable(result_i))
	else begin
		fail_cnt++;
		$error("result_o or ready_o changed while ex_ready_i was low");
	end

	//////////////////////////////
	// error flags and reset
	//////////////////////////////

	a_corr_det: assert property (@(posedge clk) disable iff (!rst_n)
		err_corrected_i |-> err_detected_i)
	else begin
		fail_cnt++;
		$error("err_corrected_o is high without err_detected_o");
	end

	a_perm_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		(perm_faulty_i & $past(perm_faulty_i)) == $past(perm_faulty_i))
	else begin
		fail_cnt++;
		$error("a perm_faulty_o bit fell while out of reset");
	end

	a_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !multicycle_i && ready_i && !err_detected_i && !err_corrected_i
			&& (perm_faulty_i == '0))
	else begin
		fail_cnt++;
		$error("a control output was not at its reset value after reset");
	end

endmodule

// lane 1 always carries the reference operation
bind mult_ft_top mult_ft_assertions i_checks (
	.clk             (clk),
	.rst_n           (rst_n),
	.lane_en_i       (enable_i[1]),
	.lane_op_i       (operator_i[1]),
	.lane_a_i        (op_a_i[1]),
	.lane_b_i        (op_b_i[1]),
	.lane_c_i        (op_c_i[1]),
	.ex_ready_i      (ex_ready_i),
	.result_i        (result_o),
	.multicycle_i    (multicycle_o),
	.ready_i         (ready_o),
	.err_detected_i  (err_detected_o),
	.err_corrected_i (err_corrected_o),
	.perm_faulty_i   (perm_faulty_o)
);

/* mult_ft_pkg.sv */
//////////////////////////////
// shared widths, counts and types of the fault tolerant multiplier
// import inside a module body, scoped names in port headers
//////////////////////////////

package mult_ft_pkg;

	//////////////////////////////
	// datapath sizes
	//////////////////////////////

	// operand and result width
	localparam int unsigned DATA_W = 32;

	// four operand lanes from the pipelines, three of them feed the replicas
	localparam int unsigned N_LANE = 4;
	localparam int unsigned N_REPLICA = 3;

	// lane that a faulty replica is switched over to
	localparam int unsigned SPARE_LANE = 3;

	//////////////////////////////
	// fault monitor
	//////////////////////////////

	localparam int unsigned FAULT_CNT_W = 3;

	// leaky counter value that marks a replica permanently faulty
	localparam logic [FAULT_CNT_W-1:0] FAULT_THRESHOLD = 3'd4;

	// operand or result word
	typedef logic [DATA_W-1:0] data_t;

	// multiplier operations
	// mul and mac finish in the issue cycle, the high halves take two cycles
	typedef enum logic [1:0] {
		MUL   = 2'b00,
		MAC   = 2'b01,
		MULH  = 2'b10,
		MULHU = 2'b11
	} mult_op_e;

	// replica state, high holds a registered upper half until ex_ready
	typedef enum logic {
		IDLE = 1'b0,
		HIGH = 1'b1
	} mult_state_e;

endpackage

/* mult_ft_top.sv */
//////////////////////////////
// triple redundant multiplier for the execute stage
// lanes 0..2 feed the replicas, lane 3 is the spare
//////////////////////////////

`timescale 1ns/1ns

module mult_ft_top (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic [mult_ft_pkg::N_LANE-1:0]       enable_i,
	input  mult_ft_pkg::mult_op_e                operator_i [mult_ft_pkg::N_LANE],
	input  mult_ft_pkg::data_t                   op_a_i [mult_ft_pkg::N_LANE],
	input  mult_ft_pkg::data_t                   op_b_i [mult_ft_pkg::N_LANE],
	input  mult_ft_pkg::data_t                   op_c_i [mult_ft_pkg::N_LANE],
	input  logic                                 ex_ready_i,
	output mult_ft_pkg::data_t                   result_o,
	output logic                                 multicycle_o,
	output logic                                 ready_o,
	output logic                                 err_detected_o,
	output logic                                 err_corrected_o,
	output logic [mult_ft_pkg::N_REPLICA-1:0]    perm_faulty_o
);
	import mult_ft_pkg::*;

	// replica outputs into the voter
	data_t [N_REPLICA-1:0] rep_result;
	logic [N_REPLICA-1:0]  rep_multicycle;
	logic [N_REPLICA-1:0]  rep_ready;
	logic [N_REPLICA-1:0]  rep_done;

	// voter to monitor and monitor back to the replicas
	logic [N_REPLICA-1:0]  mismatch;
	logic                  voted_done;
	logic [N_REPLICA-1:0]  spare_sel;

	//////////////////////////////
	// replicas
	//////////////////////////////

	for (genvar k = 0; k < N_REPLICA; k++) begin : g_core
		mult_core i_core (
			.clk              (clk),
			.rst_n            (rst_n),
			.enable_i         (enable_i[k]),
			.operator_i       (operator_i[k]),
			.op_a_i           (op_a_i[k]),
			.op_b_i           (op_b_i[k]),
			.op_c_i           (op_c_i[k]),
			.spare_enable_i   (enable_i[SPARE_LANE]),
			.spare_operator_i (operator_i[SPARE_LANE]),
			.spare_op_a_i     (op_a_i[SPARE_LANE]),
			.spare_op_b_i     (op_b_i[SPARE_LANE]),
			.spare_op_c_i     (op_c_i[SPARE_LANE]),
			.spare_sel_i      (spare_sel[k]),
			.ex_ready_i       (ex_ready_i),
			.result_o         (rep_result[k]),
			.multicycle_o     (rep_multicycle[k]),
			.ready_o          (rep_ready[k]),
			.done_o           (rep_done[k])
		);
	end

	tmr_voter i_voter (
		.result_i        (rep_result),
		.multicycle_i    (rep_multicycle),
		.ready_i         (rep_ready),
		.done_i          (rep_done),
		.result_o        (result_o),
		.multicycle_o    (multicycle_o),
		.ready_o         (ready_o),
		.done_o          (voted_done),
		.mismatch_o      (mismatch),
		.err_detected_o  (err_detected_o),
		.err_corrected_o (err_corrected_o)
	);

	fault_monitor i_monitor (
		.clk           (clk),
		.rst_n         (rst_n),
		.mismatch_i    (mismatch),
		.done_i        (voted_done),
		.ex_ready_i    (ex_ready_i),
		.spare_sel_o   (spare_sel),
		.perm_faulty_o (perm_faulty_o)
	);

endmodule

/* project.f */
mult_ft_pkg.sv
mult_core.sv
tmr_voter.sv
fault_monitor.sv
mult_ft_top.sv
mult_ft_assertions.sv
tb_mult_ft.sv

/* run_sim.sh */
#!/bin/sh
# build and run the multiplier testbench with Verilator, exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_mult_ft -f project.f &&
./obj_dir/Vtb_mult_ft +verilator+error+limit+100 ||
exit 1

/* tb_mult_ft.sv */
//////////////////////////////
// testbench for the redundant multiplier with all four lanes driven on the falling edge
// the bound assertions judge the responses
//////////////////////////////

`timescale 1ns/1ns

module tb_mult_ft;
	import mult_ft_pkg::*;

	localparam int unsigned CLK_PERIOD   = 8;
	localparam int unsigned RESET_CYCLES = 8;
	// operations in the sequence below and worst case cycles for one of them
	localparam int unsigned N_OPS        = 26;
	localparam int unsigned OP_CYCLES    = 8;
	localparam int unsigned WATCHDOG_NS  = (RESET_CYCLES + N_OPS * OP_CYCLES) * CLK_PERIOD + 400;

	logic                 clk;
	logic                 rst_n;
	logic [N_LANE-1:0]    enable_i;
	mult_op_e             operator_i [N_LANE];
	data_t                op_a_i [N_LANE];
	data_t                op_b_i [N_LANE];
	data_t                op_c_i [N_LANE];
	logic                 ex_ready_i;
	data_t                result_o;
	logic                 multicycle_o;
	logic                 ready_o;
	logic                 err_detected_o;
	logic                 err_corrected_o;
	logic [N_REPLICA-1:0] perm_faulty_o;

	// lane 3 carries the operation once replica 0 has taken the spare
	logic                 spare_on;

	mult_ft_top i_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.enable_i        (enable_i),
		.operator_i      (operator_i),
		.op_a_i          (op_a_i),
		.op_b_i          (op_b_i),
		.op_c_i          (op_c_i),
		.ex_ready_i      (ex_ready_i),
		.result_o        (result_o),
		.multicycle_o    (multicycle_o),
		.ready_o         (ready_o),
		.err_detected_o  (err_detected_o),
		.err_corrected_o (err_corrected_o),
		.perm_faulty_o   (perm_faulty_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic end_with_failure(input string why);
		$display("error: %s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$error("Fail %s got %h expected %h", name, got, exp);
			end_with_failure("an output flag has the wrong value");
		end
	endtask

	task automatic check_perm(input logic [N_REPLICA-1:0] exp);
		assert (perm_faulty_o === exp) else begin
			$error("Fail perm_faulty_o got %h expected %h", perm_faulty_o, exp);
			end_with_failure("the permanent fault flags are wrong");
		end
	endtask

	task automatic drive_lane(input int lane, input logic en, input mult_op_e op,
			input data_t a, input data_t b, input data_t c);
		enable_i[lane]   = en;
		operator_i[lane] = op;
		op_a_i[lane]     = a;
		op_b_i[lane]     = b;
		op_c_i[lane]     = c;
	endtask

	// zero operands keep all replicas equal between operations
	task automatic idle_lanes();
		for (int k = 0; k < N_LANE; k++) begin
			drive_lane(k, 1'b0, MUL, '0, '0, '0);
		end
	endtask

	// one operation from issue to acceptance
	// stall holds ex_ready low for that many cycles after ready
	task automatic run_op(input mult_op_e op, input logic bad_a0, input logic bad_b1,
			input int unsigned stall);
		data_t a;
		data_t b;
		data_t c;
		logic  seen0;
		logic  exp_det;
		logic  exp_cor;
		// odd operands make every corruption change the product
		a = $urandom() | 32'h1;
		b = $urandom() | 32'h1;
		c = $urandom();
		// lane 0 no longer counts once replica 0 runs on the spare
		seen0   = bad_a0 && !spare_on;
		exp_det = seen0 || bad_b1;
		exp_cor = seen0 != bad_b1;
		@(negedge clk);
		drive_lane(0, 1'b1, op, bad_a0 ? a + 32'd1 : a, b, c);
		drive_lane(1, 1'b1, op, a, bad_b1 ? b + 32'd2 : b, c);
		drive_lane(2, 1'b1, op, a, b, c);
		if (spare_on) begin
			drive_lane(SPARE_LANE, 1'b1, op, a, b, c);
		end
		ex_ready_i = (stall == 0);
		#2;
		if ((op == MULH) || (op == MULHU)) begin
			check_flag("multicycle_o", multicycle_o, 1'b1);
		end else begin
			// single cycle ops answer in the issue cycle
			check_flag("ready_o", ready_o, 1'b1);
		end
		// wait until the voted ready rises
		while (!ready_o) begin
			@(negedge clk);
			#2;
		end
		check_flag("err_detected_o", err_detected_o, exp_det);
		check_flag("err_corrected_o", err_corrected_o, exp_cor);
		repeat (stall) @(negedge clk);
		ex_ready_i = 1'b1;
		@(negedge clk);
		idle_lanes();
	endtask

	// pick up assertion failures of the last rising edge
	always @(negedge clk) begin
		if (i_dut.i_checks.fail_cnt != 0) begin
			end_with_failure("a DUT assertion failed");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		end_with_failure("timeout, the operations did not complete in time");
	end

	initial begin
		void'($urandom(32'h5b0e324b));
		clk        = 1'b0;
		rst_n      = 1'b0;
		ex_ready_i = 1'b1;
		spare_on   = 1'b0;
		idle_lanes();
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		// identical lanes with single cycle ops and one of them held back
		run_op(MUL, 1'b0, 1'b0, 0);
		run_op(MAC, 1'b0, 1'b0, 0);
		run_op(MUL, 1'b0, 1'b0, 3);
		run_op(MAC, 1'b0, 1'b0, 0);
		// signed and unsigned high halves with back-pressure
		run_op(MULH, 1'b0, 1'b0, 4);
		run_op(MULHU, 1'b0, 1'b0, 0);
		run_op(MULHU, 1'b0, 1'b0, 2);
		// one corrupt replica is outvoted
		run_op(MUL, 1'b1, 1'b0, 0);
		run_op(MAC, 1'b1, 1'b0, 0);
		repeat (4) run_op(MUL, 1'b0, 1'b0, 0);
		// two corrupt replicas leave no trusted result
		run_op(MUL, 1'b1, 1'b1, 0);
		// clean ops let the counters leak back to zero
		repeat (4) run_op(MAC, 1'b0, 1'b0, 0);

		// fourth corrupt op in a row crosses the threshold
		repeat (3) run_op(MUL, 1'b1, 1'b0, 0);
		check_perm(3'b000);
		run_op(MUL, 1'b1, 1'b0, 0);
		check_perm(3'b001);
		spare_on = 1'b1;
		run_op(MUL, 1'b1, 1'b0, 0);
		run_op(MAC, 1'b1, 1'b0, 0);
		run_op(MULH, 1'b1, 1'b0, 0);
		run_op(MULHU, 1'b1, 1'b0, 1);
		check_perm(3'b001);

		repeat (2) @(negedge clk);
		#1;
		if (i_dut.i_checks.fail_cnt == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			end_with_failure("assertion failures were counted");
		end
	end

endmodule

/* tmr_voter.sv */
//////////////////////////////
// bitwise majority of the three replica outputs
// flags every replica that is outvoted on result, multicycle or ready
//////////////////////////////

`timescale 1ns/1ns

module tmr_voter (
	input  mult_ft_pkg::data_t [mult_ft_pkg::N_REPLICA-1:0] result_i,
	input  logic [mult_ft_pkg::N_REPLICA-1:0]               multicycle_i,
	input  logic [mult_ft_pkg::N_REPLICA-1:0]               ready_i,
	input  logic [mult_ft_pkg::N_REPLICA-1:0]               done_i,
	output mult_ft_pkg::data_t                              result_o,
	output logic                                            multicycle_o,
	output logic                                            ready_o,
	output logic                                            done_o,
	output logic [mult_ft_pkg::N_REPLICA-1:0]               mismatch_o,
	output logic                                            err_detected_o,
	output logic                                            err_corrected_o
);
	import mult_ft_pkg::*;

	// voted fields packed into one word per replica
	logic [DATA_W+1:0] word [N_REPLICA];
	logic [DATA_W+1:0] voted;

	always_comb begin
		for (int k = 0; k < N_REPLICA; k++) begin
			word[k] = {result_i[k], multicycle_i[k], ready_i[k]};
		end
	end

	// two out of three on every bit
	assign voted = (word[0] & word[1]) | (word[1] & word[2]) | (word[0] & word[2]);

	assign result_o     = voted[DATA_W+1:2];
	assign multicycle_o = voted[1];
	assign ready_o      = voted[0];

	// done only steers the fault monitor, it is not compared
	assign done_o = (done_i[0] & done_i[1]) | (done_i[1] & done_i[2]) | (done_i[0] & done_i[2]);

	// replica k is off when any of its voted bits lost
	always_comb begin
		for (int k = 0; k < N_REPLICA; k++) begin
			mismatch_o[k] = (word[k] != voted);
		end
	end

	assign err_detected_o = |mismatch_o;
	// a single outvoted replica is masked by the other two
	assign err_corrected_o = $onehot(mismatch_o);

endmodule
